//--- sim.f
+incdir+common
common/axis_beat_pkg.sv
common/lane_pkg.sv
srl_fifo/srl_fifo.sv
source/packet_dispatch.sv
source/packet_merge.sv
source/axis_lane_buffer.sv
bench/srl_fifo_chk.sv
bench/axis_lane_buffer_tb.sv

//--- Makefile
# Verilator build and run for the lane packet buffer

VERILATOR ?= verilator
FILELIST  ?= sim.f
TOP       ?= axis_lane_buffer_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= ** PASS **

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard common/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Status comes from the pass line in the simulator output
run: $(BIN)
	@out="$$($(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/axis_lane_buffer_tb.sv
/*
 * Testbench for the lane packet buffer with clock, reset, random packets,
 * reference beats, output compare, timeout and summary
 */

`include "lane_buffer_defs.svh"

module axis_lane_buffer_tb;

    import axis_beat_pkg::*;

    localparam int READY_HIGH = 0;
    localparam int READY_LOW  = 1;
    localparam int READY_RAND = 2;
    localparam int N_RAND     = 30;
    localparam int N_CAP      = `LB_LANES * `LB_LANE_DEPTH;
    localparam int NUM_PKTS   = 1 + N_RAND + N_CAP + 3;

    logic        clk;
    logic        arst_n;
    data_t       s_axis_tdata;
    keep_t       s_axis_tkeep;
    logic        s_axis_tlast;
    logic        s_axis_tuser;
    logic        s_axis_tvalid;
    logic        s_axis_tready;
    data_t       m_axis_tdata;
    keep_t       m_axis_tkeep;
    logic        m_axis_tlast;
    logic        m_axis_tuser;
    logic        m_axis_tvalid;
    logic        m_axis_tready;
    axis_beat_t  out_word;

    int          pkt_len [NUM_PKTS];
    logic [31:0] lfsr = 32'h3cc1;
    string       test_name = "reset";
    int          ready_mode = READY_HIGH;
    int          pkt_sent = 0;
    int          out_pkt = 0;
    int          out_beat = 0;
    int          stall_count = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic        held = 1'b0;
    axis_beat_t  held_word;
    int          lane_fails [`LB_LANES];

    axis_lane_buffer i_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready)
    );

    assign out_word = {m_axis_tdata, m_axis_tkeep, m_axis_tlast, m_axis_tuser};

    for (genvar i = 0; i < `LB_LANES; i++) begin : g_fail
        assign lane_fails[i] = i_dut.g_lane[i].i_lane.i_chk.fail_count;
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // Expected beat from packet and beat number alone
    function automatic axis_beat_t expected_beat(input int pkt, input int beat);
        axis_beat_t b;
        b.data = data_t'((pkt << 16) ^ (beat * 32'h0101_0101) ^ 32'h5a00_00a5);
        b.last = (beat == pkt_len[pkt] - 1);
        b.keep = '1;
        if (b.last) begin
            b.keep = b.keep >> (pkt % 4);
        end
        b.user = pkt[0];
        return b;
    endfunction

    function automatic int assert_fails();
        int total;
        total = i_dut.i_merge.i_order_fifo.i_chk.fail_count;
        for (int i = 0; i < `LB_LANES; i++) begin
            total += lane_fails[i];
        end
        return total;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    // Packet lengths drawn up front and the cycle limit sized from their total
    task automatic plan_packets();
        int total;
        total = 0;
        pkt_len[0] = 1;
        for (int i = 1; i <= N_RAND; i++) begin
            pkt_len[i] = 1 + rand_bits(6) % 40;
        end
        for (int i = N_RAND + 1; i <= N_RAND + N_CAP; i++) begin
            pkt_len[i] = 1;
        end
        pkt_len[NUM_PKTS-3] = 24;
        pkt_len[NUM_PKTS-2] = 40;
        pkt_len[NUM_PKTS-1] = 33;
        foreach (pkt_len[i]) begin
            total += pkt_len[i];
        end
        cycle_limit = 8 * total + 500;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        case (ready_mode)
            READY_HIGH: m_axis_tready = 1'b1;
            READY_LOW:  m_axis_tready = 1'b0;
            default:    m_axis_tready = (rand_bits(2) != 0);
        endcase
    endtask

    // Starts at a falling edge and returns at the rising edge that takes the beat
    task automatic send_beat(input int pkt, input int beat);
        axis_beat_t b;
        b = expected_beat(pkt, beat);
        s_axis_tdata  = b.data;
        s_axis_tkeep  = b.keep;
        s_axis_tlast  = b.last;
        s_axis_tuser  = b.user;
        s_axis_tvalid = 1'b1;
        @(posedge clk);
        while (!s_axis_tready) begin
            stall_count++;
            next_cycle();
            @(posedge clk);
        end
    endtask

    task automatic idle();
        next_cycle();
        s_axis_tvalid = 1'b0;
    endtask

    task automatic send_packet(input int gap);
        int pkt;
        pkt = pkt_sent;
        for (int b = 0; b < pkt_len[pkt]; b++) begin
            next_cycle();
            send_beat(pkt, b);
        end
        pkt_sent++;
        if (gap > 0) begin
            idle();
            repeat (gap - 1) next_cycle();
        end
    endtask

    task automatic wait_drained();
        idle();
        while (out_pkt < pkt_sent) begin
            next_cycle();
        end
    endtask

    initial begin
        int stalls;
        arst_n        = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tlast  = 1'b0;
        s_axis_tuser  = 1'b0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        plan_packets();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        @(posedge clk);
        check_value("reset m_axis_tvalid", 64'd0, 64'(m_axis_tvalid));
        check_value("reset s_axis_tready", 64'd1, 64'(s_axis_tready));

        // Single beat visible one edge after it is taken
        test_name = "fall through";
        next_cycle();
        send_beat(0, 0);
        pkt_sent = 1;
        idle();
        @(posedge clk);
        check_value("fall through valid", 64'd1, 64'(m_axis_tvalid));
        check_value("fall through beat", 64'(expected_beat(0, 0)), 64'(out_word));
        wait_drained();

        test_name = "order and content";
        ready_mode = READY_RAND;
        repeat (N_RAND) send_packet(rand_bits(2));
        wait_drained();

        // One-beat packets into a stalled output until every lane is full
        test_name = "capacity";
        ready_mode = READY_LOW;
        stalls = stall_count;
        repeat (N_CAP) send_packet(0);
        idle();
        @(posedge clk);
        check_value("capacity stalls", 64'd0, 64'(stall_count - stalls));
        check_value("capacity s_axis_tready", 64'd0, 64'(s_axis_tready));
        ready_mode = READY_HIGH;
        wait_drained();

        test_name = "long packets";
        repeat (3) send_packet(0);
        wait_drained();

        test_name = "end";
        @(posedge clk);
        check_value("end m_axis_tvalid", 64'd0, 64'(m_axis_tvalid));
        check_value("end packets out", 64'(NUM_PKTS), 64'(out_pkt));
        $display("Summary: %0d errors, %0d assertion failures", errors, assert_fails());
        if (errors == 0 && assert_fails() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Output compare at the rising edge
    always @(posedge clk) begin
        axis_beat_t exp_word;
        if (arst_n) begin
            if (held) begin
                check_value({test_name, " hold valid"}, 64'd1, 64'(m_axis_tvalid));
                check_value({test_name, " hold beat"}, 64'(held_word), 64'(out_word));
            end
            if (m_axis_tvalid && m_axis_tready) begin
                if (out_pkt >= NUM_PKTS) begin
                    $display("Extra output beat after all %0d packets arrived", NUM_PKTS);
                    errors++;
                end else begin
                    exp_word = expected_beat(out_pkt, out_beat);
                    check_value(test_name, 64'(exp_word), 64'(out_word));
                    if (out_beat == pkt_len[out_pkt] - 1) begin
                        out_pkt++;
                        out_beat = 0;
                    end else begin
                        out_beat++;
                    end
                end
            end
            held      = m_axis_tvalid && !m_axis_tready;
            held_word = out_word;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles, %0d of %0d packets delivered",
                     cycles, out_pkt, NUM_PKTS);
            $display("Summary: %0d errors, %0d assertion failures", errors, assert_fails());
            $display("** FAIL **");
            $finish;
        end
    end

endmodule

//--- bench/srl_fifo_chk.sv
/*
 * Concurrent assertions for the shift-register FIFO bound to every instance
 */

module srl_fifo_chk #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [7:0]
) (
    input logic                       clk,
    input logic                       arst_n,
    input payload_t                   in_data,
    input logic                       in_valid,
    input logic                       in_ready,
    input payload_t                   out_data,
    input logic                       out_valid,
    input logic                       out_ready,
    input logic [$clog2(DEPTH+1)-1:0] count
);

    logic push;
    logic pop;
    int   fail_count = 0;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Empty and open on the first edge after reset release
    a_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> (count == '0) && !out_valid && in_ready)
        else begin
            fail_count++;
            $error("FIFO not empty and open after reset");
        end

    a_ready: assert property (@(posedge clk) disable iff (!arst_n)
        in_ready == (int'(count) != DEPTH))
        else begin
            fail_count++;
            $error("in_ready does not match the full state");
        end

    a_valid: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == (count != '0))
        else begin
            fail_count++;
            $error("out_valid does not match the empty state");
        end

    a_bound: assert property (@(posedge clk) disable iff (!arst_n)
        int'(count) <= DEPTH)
        else begin
            fail_count++;
            $error("count above the FIFO depth");
        end

    // Count follows writes minus reads
    a_step: assert property (@(posedge clk) disable iff (!arst_n)
        int'(count) == int'($past(count)) + int'($past(push)) - int'($past(pop)))
        else begin
            fail_count++;
            $error("count moved by more than writes minus reads");
        end

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            fail_count++;
            $error("head entry changed while stalled");
        end

    // Write into an empty FIFO shows at the head one cycle later
    a_fall: assert property (@(posedge clk) disable iff (!arst_n)
        push && !out_valid |=> out_valid && (out_data == $past(in_data)))
        else begin
            fail_count++;
            $error("written entry did not fall through");
        end

endmodule

bind srl_fifo srl_fifo_chk #(
    .DEPTH     (DEPTH),
    .payload_t (payload_t)
) i_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .count     (count)
);

//--- source/axis_lane_buffer.sv
/*
 * Lane packet buffer top level with the dispatcher, lane FIFOs and merger
 */

`include "lane_buffer_defs.svh"

module axis_lane_buffer (
    input  logic                 clk,
    input  logic                 arst_n,

    input  axis_beat_pkg::data_t s_axis_tdata,
    input  axis_beat_pkg::keep_t s_axis_tkeep,
    input  logic                 s_axis_tlast,
    input  logic                 s_axis_tuser,
    input  logic                 s_axis_tvalid,
    output logic                 s_axis_tready,

    output axis_beat_pkg::data_t m_axis_tdata,
    output axis_beat_pkg::keep_t m_axis_tkeep,
    output logic                 m_axis_tlast,
    output logic                 m_axis_tuser,
    output logic                 m_axis_tvalid,
    input  logic                 m_axis_tready
);

    import axis_beat_pkg::*;
    import lane_pkg::*;

    // Shared write bus from the dispatcher
    axis_beat_t           wr_beat;
    logic [`LB_LANES-1:0] wr_valid;
    logic [`LB_LANES-1:0] wr_ready;
    fill_cnt_t            lane_count [`LB_LANES];

    // Lane heads toward the merger
    axis_beat_t           rd_beat [`LB_LANES];
    logic [`LB_LANES-1:0] rd_valid;
    logic [`LB_LANES-1:0] rd_ready;

    logic                 order_valid;
    lane_idx_t            order_lane;
    logic                 order_ready;

    packet_dispatch i_dispatch (
        .clk           (clk),
        .arst_n        (arst_n),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .lane_beat     (wr_beat),
        .lane_valid    (wr_valid),
        .lane_ready    (wr_ready),
        .lane_count    (lane_count),
        .order_valid   (order_valid),
        .order_lane    (order_lane),
        .order_ready   (order_ready)
    );

    for (genvar i = 0; i < `LB_LANES; i++) begin : g_lane
        srl_fifo #(
            .DEPTH     (`LB_LANE_DEPTH),
            .payload_t (axis_beat_t)
        ) i_lane (
            .clk       (clk),
            .arst_n    (arst_n),
            .in_data   (wr_beat),
            .in_valid  (wr_valid[i]),
            .in_ready  (wr_ready[i]),
            .out_data  (rd_beat[i]),
            .out_valid (rd_valid[i]),
            .out_ready (rd_ready[i]),
            .count     (lane_count[i])
        );
    end

    packet_merge i_merge (
        .clk           (clk),
        .arst_n        (arst_n),
        .order_valid   (order_valid),
        .order_lane    (order_lane),
        .order_ready   (order_ready),
        .lane_beat     (rd_beat),
        .lane_valid    (rd_valid),
        .lane_ready    (rd_ready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready)
    );

endmodule

//--- source/packet_merge.sv
/*
 * Packet merger that keeps the order queue and forwards beats from the
 * head lane until the last beat of each packet
 */

`include "lane_buffer_defs.svh"

module packet_merge (
    input  logic                      clk,
    input  logic                      arst_n,

    input  logic                      order_valid,
    input  lane_pkg::lane_idx_t       order_lane,
    output logic                      order_ready,

    input  axis_beat_pkg::axis_beat_t lane_beat [`LB_LANES],
    input  logic [`LB_LANES-1:0]      lane_valid,
    output logic [`LB_LANES-1:0]      lane_ready,

    output axis_beat_pkg::data_t      m_axis_tdata,
    output axis_beat_pkg::keep_t      m_axis_tkeep,
    output logic                      m_axis_tlast,
    output logic                      m_axis_tuser,
    output logic                      m_axis_tvalid,
    input  logic                      m_axis_tready
);

    import lane_pkg::*;
    import axis_beat_pkg::*;

    lane_idx_t  head_lane;
    logic       head_valid;
    logic       head_pop;
    axis_beat_t head_beat;

    // Lane numbers in packet arrival order
    srl_fifo #(
        .DEPTH     (`LB_ORDER_DEPTH),
        .payload_t (lane_idx_t)
    ) i_order_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (order_lane),
        .in_valid  (order_valid),
        .in_ready  (order_ready),
        .out_data  (head_lane),
        .out_valid (head_valid),
        .out_ready (head_pop),
        .count     ()
    );

    assign head_beat = lane_beat[head_lane];

    assign m_axis_tdata  = head_beat.data;
    assign m_axis_tkeep  = head_beat.keep;
    assign m_axis_tlast  = head_beat.last;
    assign m_axis_tuser  = head_beat.user;
    assign m_axis_tvalid = head_valid && lane_valid[head_lane];

    // Only the head lane ever sees ready
    always_comb begin
        lane_ready = '0;
        lane_ready[head_lane] = head_valid && m_axis_tready;
    end

    // Move to the next lane once the packet's last beat leaves
    assign head_pop = m_axis_tvalid && m_axis_tready && m_axis_tlast;

endmodule

//--- source/packet_dispatch.sv
/*
 * Packet dispatcher that picks the least-filled lane at each packet start,
 * steers the beats into it and posts the lane number to the order queue
 */

`include "lane_buffer_defs.svh"

module packet_dispatch (
    input  logic                     clk,
    input  logic                     arst_n,

    input  axis_beat_pkg::data_t     s_axis_tdata,
    input  axis_beat_pkg::keep_t     s_axis_tkeep,
    input  logic                     s_axis_tlast,
    input  logic                     s_axis_tuser,
    input  logic                     s_axis_tvalid,
    output logic                     s_axis_tready,

    output axis_beat_pkg::axis_beat_t lane_beat,
    output logic [`LB_LANES-1:0]     lane_valid,
    input  logic [`LB_LANES-1:0]     lane_ready,
    input  lane_pkg::fill_cnt_t      lane_count [`LB_LANES],

    output logic                     order_valid,
    output lane_pkg::lane_idx_t      order_lane,
    input  logic                     order_ready
);

    import lane_pkg::*;

    lane_idx_t pick_lane;
    fill_cnt_t pick_count;
    lane_idx_t lock_lane;
    logic      mid_pkt;
    lane_idx_t cur_lane;
    logic      beat_fire;

    // Smallest count wins and ties stay on the lower index
    always_comb begin
        pick_lane  = '0;
        pick_count = lane_count[0];
        for (int i = 1; i < `LB_LANES; i++) begin
            if (lane_count[i] < pick_count) begin
                pick_lane  = lane_idx_t'(i);
                pick_count = lane_count[i];
            end
        end
    end

    assign cur_lane = mid_pkt ? lock_lane : pick_lane;

    // A first beat also needs room in the order queue
    assign s_axis_tready = lane_ready[cur_lane] && (mid_pkt || order_ready);
    assign beat_fire     = s_axis_tvalid && s_axis_tready;

    assign lane_beat.data = s_axis_tdata;
    assign lane_beat.keep = s_axis_tkeep;
    assign lane_beat.last = s_axis_tlast;
    assign lane_beat.user = s_axis_tuser;

    always_comb begin
        lane_valid = '0;
        lane_valid[cur_lane] = s_axis_tvalid && (mid_pkt || order_ready);
    end

    // Posted once per packet on the same edge as the first beat
    assign order_valid = s_axis_tvalid && !mid_pkt && lane_ready[cur_lane];
    assign order_lane  = cur_lane;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid_pkt   <= 1'b0;
            lock_lane <= '0;
        end else if (beat_fire) begin
            mid_pkt   <= !s_axis_tlast;
            lock_lane <= cur_lane;
        end
    end

endmodule

//--- srl_fifo/srl_fifo.sv
/*
 * First-word-fall-through shift-register FIFO with a payload type
 * parameter and an occupancy count
 */

module srl_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [7:0]
) (
    input  logic                       clk,
    input  logic                       arst_n,

    input  payload_t                   in_data,
    input  logic                       in_valid,
    output logic                       in_ready,

    output payload_t                   out_data,
    output logic                       out_valid,
    input  logic                       out_ready,

    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PTR_W  = $clog2(DEPTH + 1);
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t             data_reg [DEPTH];
    logic [PTR_W-1:0]     ptr_reg;
    logic                 full_reg;
    logic                 empty_reg;
    logic                 shift;
    logic                 pop;
    logic [ADDR_W-1:0]    rd_idx;

    // Every accepted write shifts the whole register by one
    assign shift = in_valid && in_ready;
    assign pop   = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (shift) begin
            data_reg[0] <= in_data;
            for (int i = 1; i < DEPTH; i++) begin
                data_reg[i] <= data_reg[i-1];
            end
        end
    end

    // Pointer tracks occupancy with the flags kept alongside
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr_reg   <= '0;
            full_reg  <= 1'b0;
            empty_reg <= 1'b1;
        end else if (shift && !pop) begin
            ptr_reg   <= ptr_reg + 1'b1;
            empty_reg <= 1'b0;
            full_reg  <= (ptr_reg == PTR_W'(DEPTH - 1));
        end else if (pop && !shift) begin
            ptr_reg   <= ptr_reg - 1'b1;
            full_reg  <= 1'b0;
            empty_reg <= (ptr_reg == PTR_W'(1));
        end
    end

    // Oldest entry sits one below the pointer
    assign rd_idx = empty_reg ? '0 : ADDR_W'(ptr_reg - 1'b1);

    assign out_data  = data_reg[rd_idx];
    assign out_valid = !empty_reg;
    assign in_ready  = !full_reg;
    assign count     = ptr_reg;

endmodule

//--- common/lane_pkg.sv
/*
 * Lane bookkeeping types
 * Lane number and lane fill count
 */

`include "lane_buffer_defs.svh"

package lane_pkg;

    localparam int LANE_IDX_W = (`LB_LANES > 1) ? $clog2(`LB_LANES) : 1;
    localparam int FILL_CNT_W = $clog2(`LB_LANE_DEPTH + 1);

    typedef logic [LANE_IDX_W-1:0] lane_idx_t;

    // Counts 0 up to the full lane depth inclusive
    typedef logic [FILL_CNT_W-1:0] fill_cnt_t;

endpackage

//--- common/axis_beat_pkg.sv
/*
 * Stream beat types
 * Data and keep field types and the packed beat struct
 */

`include "lane_buffer_defs.svh"

package axis_beat_pkg;

    localparam int KEEP_W = `LB_DATA_W / 8;

    typedef logic [`LB_DATA_W-1:0] data_t;
    typedef logic [KEEP_W-1:0]     keep_t;

    // One lane entry of 38 bits with the default width
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } axis_beat_t;

endpackage

//--- common/lane_buffer_defs.svh
/*
 * Sizing macros for the lane packet buffer
 * Beat data width, lane count, lane depth and order queue depth
 */

`ifndef LANE_BUFFER_DEFS_SVH
`define LANE_BUFFER_DEFS_SVH

// Beat data width in bits as a whole number of bytes
`define LB_DATA_W 32

// Number of lane FIFOs behind the dispatcher
`define LB_LANES 4

// Beats held by one lane
`define LB_LANE_DEPTH 16

// One order entry per packet that can be in flight
`define LB_ORDER_DEPTH (`LB_LANES * `LB_LANE_DEPTH)

`endif
